// File: source/tcdm_pkg.sv
// Payload types of the TCDM request and response channels.
// Shared by the arbitration tree, the response router and the top level.
// Modules use these types by scoped name in their ports and by a
// wildcard import in their bodies.

package tcdm_pkg;

    ////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    // One enable per byte lane
    localparam int BE_W = DATA_W / 8;
    // Master index field, room for up to 16 masters
    localparam int MAX_MASTER_W = 4;

    ////////////////////////////////////////////////////////////
    // Request and response payloads
    ////////////////////////////////////////////////////////////

    // Request from a core port towards the bank
    typedef struct packed {
        logic [ADDR_W-1:0]       addr;
        // Write enable, low for a read
        logic                    wen;
        logic [BE_W-1:0]         be;
        logic [DATA_W-1:0]       wdata;
        // Index of the issuing master, stamped at the top level
        logic [MAX_MASTER_W-1:0] src;
    } tcdm_req_t;

    // Read response from the bank back to a master
    typedef struct packed {
        logic [DATA_W-1:0]       rdata;
        // Copied from the request so the router finds the master
        logic [MAX_MASTER_W-1:0] src;
    } tcdm_resp_t;

endpackage

// File: source/arb_pkg.sv
// Bookkeeping for the distributed round-robin arbiter.
// Holds the priority flag vector and the tree depth helper used by
// the arbitration tree and the round-robin counter.

package arb_pkg;

    // Deepest tree supported, 16 masters
    localparam int MAX_LEV = 4;

    // One priority flag per tree level, bit 0 feeds the root
    typedef logic [MAX_LEV-1:0] prio_t;

    // Number of two-input levels between n_master leaves and the root
    function automatic int arb_levels(input int n_master);
        int lev;
        lev = 0;
        // Smallest lev with 2**lev covering all masters
        while ((1 << lev) < n_master)
        begin
            lev = lev + 1;
        end
        return lev;
    endfunction

endpackage

// File: source/fan_in_req.sv
// Two-input round-robin fan-in node of the request tree.
// Merges two request channels into one and routes the downstream
// grant back to the side that won. Purely combinational.

`timescale 1ns/1ps

module fan_in_req
(
    // Priority flag of this tree level, 1 favours input 1
    input  logic                 prio_i,

    // Input side, two request channels
    input  logic                 req0_i,
    input  logic                 req1_i,
    input  tcdm_pkg::tcdm_req_t  data0_i,
    input  tcdm_pkg::tcdm_req_t  data1_i,
    output logic                 gnt0_o,
    output logic                 gnt1_o,

    // Output side, towards the root
    output logic                 req_o,
    output tcdm_pkg::tcdm_req_t  data_o,
    input  logic                 gnt_i
);

    // Mux select, 1 picks input 1
    logic sel;

    ////////////////////////////////////////////////////////////
    // Arbitration
    ////////////////////////////////////////////////////////////

    // Either side requesting makes this node request
    assign req_o = req0_i | req1_i;

    // Input 1 wins if input 0 is idle, or on a tie with the flag set
    assign sel = ~req0_i | (prio_i & req1_i);

    // Grant only goes back when the node itself is granted
    // Input 0 wins alone or on a tie with the flag clear
    assign gnt0_o = ((req0_i & ~req1_i) | (req0_i & ~prio_i)) & gnt_i;
    assign gnt1_o = ((~req0_i & req1_i) | (req1_i & prio_i)) & gnt_i;

    ////////////////////////////////////////////////////////////
    // Payload mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (sel)
            1'b0:
            begin
                data_o = data0_i;
            end
            default:
            begin
                data_o = data1_i;
            end
        endcase
    end

endmodule

// File: source/arb_tree_req.sv
// Binary arbitration tree of fan_in_req nodes.
// N_MASTER leaves are merged level by level down to one root request.
// Level depth d (root at depth 0) takes priority flag bit d, so the
// root sees bit 0. With two masters the tree is the root node alone.

`timescale 1ns/1ps

module arb_tree_req
#(
    parameter int N_MASTER = 8
)
(
    // Per-level priority flags from the round-robin counter
    input  arb_pkg::prio_t                       prio_i,

    // Master side
    input  logic [N_MASTER-1:0]                  req_i,
    input  tcdm_pkg::tcdm_req_t [N_MASTER-1:0]   data_i,
    output logic [N_MASTER-1:0]                  gnt_o,

    // Root side, towards the bank
    output logic                                 req_o,
    output tcdm_pkg::tcdm_req_t                  data_o,
    input  logic                                 gnt_i
);

    import tcdm_pkg::*;
    import arb_pkg::*;

    localparam int N_LEV   = arb_levels(N_MASTER);
    // Heap layout, internal nodes first, then the leaves
    localparam int N_NODES = 2 * N_MASTER - 1;
    localparam int LEAF0   = N_MASTER - 1;

    // Node k has children 2k+1 and 2k+2, node 0 is the root
    logic      req_n  [N_NODES];
    tcdm_req_t data_n [N_NODES];
    logic      gnt_n  [N_NODES];

    ////////////////////////////////////////////////////////////
    // Leaves
    ////////////////////////////////////////////////////////////

    // Master m sits at heap slot LEAF0+m
    // so masters 2k and 2k+1 share a bottom-level node
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_leaf
        assign req_n[LEAF0+m]  = req_i[m];
        assign data_n[LEAF0+m] = data_i[m];
        assign gnt_o[m]        = gnt_n[LEAF0+m];
    end

    ////////////////////////////////////////////////////////////
    // Internal levels
    ////////////////////////////////////////////////////////////

    for (genvar d = 0; d < N_LEV; d++)
    begin : g_level
        // First heap slot at this depth
        localparam int FIRST = (1 << d) - 1;

        for (genvar k = 0; k < (1 << d); k++)
        begin : g_node
            localparam int NODE = FIRST + k;

            // All nodes at one depth share the same flag
            fan_in_req u_node
            (
                .prio_i  (prio_i[d]),
                .req0_i  (req_n[2*NODE+1]),
                .req1_i  (req_n[2*NODE+2]),
                .data0_i (data_n[2*NODE+1]),
                .data1_i (data_n[2*NODE+2]),
                .gnt0_o  (gnt_n[2*NODE+1]),
                .gnt1_o  (gnt_n[2*NODE+2]),
                .req_o   (req_n[NODE]),
                .data_o  (data_n[NODE]),
                .gnt_i   (gnt_n[NODE])
            );
        end
    end

    ////////////////////////////////////////////////////////////
    // Root
    ////////////////////////////////////////////////////////////

    assign req_o    = req_n[0];
    assign data_o   = data_n[0];
    // Bank grant enters the tree at the root
    assign gnt_n[0] = gnt_i;

endmodule

// File: source/rr_prio_counter.sv
// Round-robin state of the distributed arbiter.
// A binary counter steps on every accepted root request. Counter bit d
// drives the flag of tree depth d, so the root alternates on every
// grant and deeper levels rotate at half the rate of the one above.

`timescale 1ns/1ps

module rr_prio_counter
#(
    parameter int N_MASTER = 8
)
(
    input  logic            clk_i,
    input  logic            rst_i,

    // Root request accepted by the bank this cycle
    input  logic            advance_i,

    output arb_pkg::prio_t  prio_o
);

    import arb_pkg::*;

    localparam int N_LEV = arb_levels(N_MASTER);

    logic [N_LEV-1:0] cnt_q;

    // Wraps naturally at N_MASTER
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            cnt_q <= '0;
        end
        else if (advance_i)
        begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // Flags above the tree depth stay at zero
    always_comb
    begin
        prio_o              = '0;
        prio_o[N_LEV-1:0]   = cnt_q;
    end

endmodule

// File: source/resp_route.sv
// Read response router.
// Decodes the src field of each bank response into a one-hot valid
// vector over the masters and registers it with the read data, so
// the addressed master sees its response one cycle after the bank.

`timescale 1ns/1ps

module resp_route
#(
    parameter int N_MASTER = 8
)
(
    input  logic                        clk_i,
    input  logic                        rst_i,

    // Bank response channel
    input  logic                        rvalid_i,
    input  tcdm_pkg::tcdm_resp_t        resp_i,

    // One-hot valid, shared data bus
    output logic [N_MASTER-1:0]         rvalid_o,
    output logic [tcdm_pkg::DATA_W-1:0] rdata_o
);

    import tcdm_pkg::*;

    // Bits of src actually needed to name a master
    localparam int IDX_W = $clog2(N_MASTER);

    logic [N_MASTER-1:0] valid_dec;
    logic [N_MASTER-1:0] rvalid_q;
    logic [DATA_W-1:0]   rdata_q;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        valid_dec = '0;
        if (rvalid_i)
        begin
            valid_dec[resp_i.src[IDX_W-1:0]] = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Output registers
    ////////////////////////////////////////////////////////////

    // Valid is a one-cycle pulse, dropped when no response arrives
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            rvalid_q <= '0;
        end
        else
        begin
            rvalid_q <= valid_dec;
        end
    end

    // Data only loads with a response, holds otherwise
    always_ff @(posedge clk_i)
    begin
        if (rvalid_i)
        begin
            rdata_q <= resp_i.rdata;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;

endmodule

// File: source/log_xbar_top.sv
// Request side of a logarithmic TCDM interconnect, N_MASTER to one bank.
// Requests pass combinationally through a round-robin tree to the bank
// port, grants come straight back. Read responses are steered to the
// master named in their src field, one cycle after the bank.

`timescale 1ns/1ps

module log_xbar_top
#(
    // Power of two, 2 to 16
    parameter int N_MASTER = 8
)
(
    input  logic                                 clk_i,
    input  logic                                 rst_i,

    // Master ports, indexed by master
    input  logic [N_MASTER-1:0]                  req_i,
    input  tcdm_pkg::tcdm_req_t [N_MASTER-1:0]   req_data_i,
    output logic [N_MASTER-1:0]                  gnt_o,

    // Bank request port
    output logic                                 bank_req_o,
    output tcdm_pkg::tcdm_req_t                  bank_req_data_o,
    input  logic                                 bank_gnt_i,

    // Bank response port
    input  logic                                 bank_rvalid_i,
    input  tcdm_pkg::tcdm_resp_t                 bank_resp_i,

    // Responses to masters
    output logic [N_MASTER-1:0]                  rvalid_o,
    output logic [tcdm_pkg::DATA_W-1:0]          rdata_o
);

    import tcdm_pkg::*;
    import arb_pkg::*;

    tcdm_req_t [N_MASTER-1:0] req_stamped;
    prio_t                    prio;
    // Root request taken by the bank
    logic                     advance;

    ////////////////////////////////////////////////////////////
    // Source stamping
    ////////////////////////////////////////////////////////////

    // Overwrite src with the port index, whatever the master drove
    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            req_stamped[m]     = req_data_i[m];
            req_stamped[m].src = MAX_MASTER_W'(m);
        end
    end

    ////////////////////////////////////////////////////////////
    // Request path
    ////////////////////////////////////////////////////////////

    arb_tree_req #(.N_MASTER(N_MASTER)) u_tree
    (
        .prio_i  (prio),
        .req_i   (req_i),
        .data_i  (req_stamped),
        .gnt_o   (gnt_o),
        .req_o   (bank_req_o),
        .data_o  (bank_req_data_o),
        .gnt_i   (bank_gnt_i)
    );

    assign advance = bank_req_o & bank_gnt_i;

    // Priority moves on the edge after an accepted request
    rr_prio_counter #(.N_MASTER(N_MASTER)) u_rr
    (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .advance_i (advance),
        .prio_o    (prio)
    );

    ////////////////////////////////////////////////////////////
    // Response path
    ////////////////////////////////////////////////////////////

    resp_route #(.N_MASTER(N_MASTER)) u_resp
    (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .rvalid_i (bank_rvalid_i),
        .resp_i   (bank_resp_i),
        .rvalid_o (rvalid_o),
        .rdata_o  (rdata_o)
    );

endmodule

// File: bench/tb_ref_model.svh
// Reference model of the request tree and the response router.
// Included in the testbench module body after the tcdm_pkg import,
// relies on the testbench constant N_MST.

`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Model round-robin counter, steps on every accepted request
int unsigned model_cnt;

// One-hot master vector for a master index
function automatic logic [N_MST-1:0] onehot(input int idx);
    logic [N_MST-1:0] v;
    v = '0;
    v[idx] = 1'b1;
    return v;
endfunction

// Request as it should leave the tree, src replaced by the port index
function automatic tcdm_req_t stamp_src(input tcdm_req_t d, input int idx);
    tcdm_req_t r;
    r = d;
    r.src = MAX_MASTER_W'(idx);
    return r;
endfunction

// Winning master for counter value cnt, -1 when nobody requests
// Walks from the root down and halves the master range per level
function automatic int pick_winner(input logic [N_MST-1:0] req, input int unsigned cnt);
    int lo;
    int size;
    int depth;
    bit lo_any;
    bit hi_any;
    lo = 0;
    size = N_MST;
    depth = 0;
    if (req == '0)
    begin
        return -1;
    end
    while (size > 1)
    begin
        lo_any = 1'b0;
        hi_any = 1'b0;
        for (int i = 0; i < size / 2; i++)
        begin
            lo_any = lo_any | req[lo+i];
            hi_any = hi_any | req[lo+size/2+i];
        end
        // Upper half wins alone, or on a tie with this level's flag set
        if (hi_any && (!lo_any || ((cnt >> depth) & 1) != 0))
        begin
            lo = lo + size / 2;
        end
        size = size / 2;
        depth = depth + 1;
    end
    return lo;
endfunction

`endif

// File: bench/tb_log_xbar.sv
// Testbench for the logarithmic TCDM request interconnect.
// Random masters and a random bank model drive the DUT. Every cycle the
// grants, the bank payload and the routed responses are compared with
// the included reference model. Phases: reset, single requesters,
// all masters requesting, random traffic, drain.

`timescale 1ns/1ps

module tb_log_xbar;

    import tcdm_pkg::*;

    localparam int          N_MST        = 8;
    localparam int          CLK_PERIOD   = 40;
    localparam int          RST_CYCLES   = 16;
    localparam int          FAIR_CYCLES  = 16;
    localparam int          RAND_CYCLES  = 2000;
    // Headroom for held requests and late reads after the random phase
    localparam int          DRAIN_CYCLES = 460;
    localparam int          TIMEOUT      = RST_CYCLES + N_MST + FAIR_CYCLES
                                           + RAND_CYCLES + DRAIN_CYCLES;
    localparam int unsigned SEED         = 32'h24da_30ee;

    // Stimulus phases
    localparam int MODE_IDLE  = 0;
    localparam int MODE_SOLO  = 1;
    localparam int MODE_FAIR  = 2;
    localparam int MODE_RAND  = 3;
    localparam int MODE_DRAIN = 4;

    logic                  clk;
    logic                  rst;
    logic [N_MST-1:0]      req;
    tcdm_req_t [N_MST-1:0] req_data;
    logic [N_MST-1:0]      gnt;
    logic                  bank_req;
    tcdm_req_t             bank_req_data;
    logic                  bank_gnt;
    logic                  bank_rvalid;
    tcdm_resp_t            bank_resp;
    logic [N_MST-1:0]      rvalid;
    logic [DATA_W-1:0]     rdata;

    int                mode;
    int                solo;
    int                cyc;
    int                run_cyc;
    int                errors;
    int                checks;
    // Masters granted this cycle, they drop their request next cycle
    logic [N_MST-1:0]  taken;
    // Bank read queue, master index and due cycle per entry
    int                pend_src[$];
    int                pend_due[$];
    // Response driven this cycle and the one before
    logic              cur_rv;
    int                cur_src;
    logic [DATA_W-1:0] cur_data;
    logic              prev_rv;
    int                prev_src;
    logic [DATA_W-1:0] prev_data;
    // Masters granted by the DUT in the current window of N_MST fair grants
    logic [N_MST-1:0]  fair_mask;
    int                fair_cnt;

    `include "tb_ref_model.svh"

    log_xbar_top #(.N_MASTER(N_MST)) dut
    (
        .clk_i           (clk),
        .rst_i           (rst),
        .req_i           (req),
        .req_data_i      (req_data),
        .gnt_o           (gnt),
        .bank_req_o      (bank_req),
        .bank_req_data_o (bank_req_data),
        .bank_gnt_i      (bank_gnt),
        .bank_rvalid_i   (bank_rvalid),
        .bank_resp_i     (bank_resp),
        .rvalid_o        (rvalid),
        .rdata_o         (rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Hard limit on the run length
    always @(posedge clk)
    begin
        run_cyc++;
        if (run_cyc > TIMEOUT)
        begin
            $display("Timeout: simulation still running after %0d cycles", TIMEOUT);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////

    task automatic compare_val(input logic [127:0] got, input logic [127:0] exp,
                               input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] time %0t: %s mismatch, got %0h expected %0h",
                     $time, what, got, exp);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Masters and bank model
    ////////////////////////////////////////////////////////////

    task automatic drive_inputs();
        int due_idx[$];
        int pick;
        // Initial value of rst covers the first edge
        rst = (cyc < RST_CYCLES - 1);
        for (int m = 0; m < N_MST; m++)
        begin
            if (taken[m] || (mode == MODE_SOLO && m != solo))
            begin
                req[m] = 1'b0;
            end
            if (!req[m] && (mode == MODE_FAIR || (mode == MODE_SOLO && m == solo)
                            || (mode == MODE_RAND && $urandom_range(1, 0) == 1)))
            begin
                req[m]             = 1'b1;
                req_data[m].addr   = $urandom;
                req_data[m].wen    = 1'($urandom_range(1, 0));
                req_data[m].be     = BE_W'($urandom_range(15, 0));
                req_data[m].wdata  = $urandom;
                // Junk src, the DUT has to overwrite it
                req_data[m].src    = MAX_MASTER_W'($urandom_range(15, 0));
            end
        end
        taken = '0;
        if (mode == MODE_SOLO || mode == MODE_FAIR)
        begin
            bank_gnt = 1'b1;
        end
        else if (mode == MODE_IDLE)
        begin
            bank_gnt = 1'b0;
        end
        else
        begin
            // Grant about 70 percent of the cycles
            bank_gnt = ($urandom_range(9, 0) < 7);
        end
        for (int i = 0; i < pend_src.size(); i++)
        begin
            if (pend_due[i] <= cyc)
            begin
                due_idx.push_back(i);
            end
        end
        cur_rv = 1'b0;
        if (due_idx.size() > 0)
        begin
            // Any due read may go first, so returns overtake each other
            pick     = due_idx[$urandom_range(due_idx.size() - 1, 0)];
            cur_rv   = 1'b1;
            cur_src  = pend_src[pick];
            cur_data = $urandom;
            pend_src.delete(pick);
            pend_due.delete(pick);
        end
        bank_rvalid     = cur_rv;
        bank_resp.rdata = cur_data;
        bank_resp.src   = MAX_MASTER_W'(cur_src);
    endtask

    // Compare this cycle against the model, then advance the model
    task automatic score_cycle();
        int               w;
        logic [N_MST-1:0] exp_gnt;
        w = pick_winner(req, model_cnt);
        exp_gnt = (w >= 0 && bank_gnt) ? onehot(w) : '0;
        compare_val(128'(bank_req), 128'(w >= 0), "bank request");
        compare_val(128'(gnt), 128'(exp_gnt), "master grants");
        if (w >= 0)
        begin
            compare_val(128'(bank_req_data), 128'(stamp_src(req_data[w], w)), "bank payload");
        end
        // Routed response of the previous cycle
        compare_val(128'(rvalid), 128'(prev_rv ? onehot(prev_src) : '0), "response valid");
        if (prev_rv)
        begin
            compare_val(128'(rdata), 128'(prev_data), "response data");
        end
        if (!rst && w >= 0 && bank_gnt)
        begin
            model_cnt = (model_cnt + 1) % N_MST;
            taken[w] = 1'b1;
            // Reads return from the bank after 1 to 4 cycles
            if (!req_data[w].wen)
            begin
                pend_src.push_back(w);
                pend_due.push_back(cyc + int'($urandom_range(4, 1)));
            end
            if (mode == MODE_FAIR)
            begin
                fair_mask = fair_mask | gnt;
                fair_cnt++;
                if (fair_cnt % N_MST == 0)
                begin
                    compare_val(128'(fair_mask), 128'({N_MST{1'b1}}), "round-robin coverage");
                    fair_mask = '0;
                end
            end
        end
        prev_rv   = cur_rv;
        prev_src  = cur_src;
        prev_data = cur_data;
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #2;
        drive_inputs();
        // Sample well clear of both clock edges
        #16;
        score_cycle();
        cyc++;
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(SEED));
        rst         = 1'b1;
        req         = '0;
        req_data    = '0;
        bank_gnt    = 1'b0;
        bank_rvalid = 1'b0;
        bank_resp   = '0;
        mode        = MODE_IDLE;
        solo        = 0;
        cyc         = 0;
        run_cyc     = 0;
        errors      = 0;
        checks      = 0;
        taken       = '0;
        model_cnt   = 0;
        cur_rv      = 1'b0;
        cur_src     = 0;
        cur_data    = '0;
        prev_rv     = 1'b0;
        prev_src    = 0;
        prev_data   = '0;
        fair_mask   = '0;
        fair_cnt    = 0;
        // Reset, rvalid stays low and the counter at zero
        repeat (RST_CYCLES) run_cycle();
        // One lone requester per cycle, flags differ each time
        mode = MODE_SOLO;
        for (int m = 0; m < N_MST; m++)
        begin
            solo = m;
            run_cycle();
        end
        // Everyone requesting, bank always ready
        mode = MODE_FAIR;
        repeat (FAIR_CYCLES) run_cycle();
        mode = MODE_RAND;
        repeat (RAND_CYCLES) run_cycle();
        // Let held requests and outstanding reads finish
        mode = MODE_DRAIN;
        while (req != '0 || pend_src.size() > 0 || prev_rv)
        begin
            run_cycle();
        end
        $display("Run finished: %0d cycles, %0d checks, %0d errors", cyc, checks, errors);
        if (errors == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: tb.f
+incdir+bench
source/tcdm_pkg.sv
source/arb_pkg.sv
source/fan_in_req.sv
source/arb_tree_req.sv
source/rr_prio_counter.sv
source/resp_route.sv
source/log_xbar_top.sv
bench/tb_log_xbar.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing -j 0
TOP      := tb_log_xbar
FILELIST := tb.f
BUILD    := obj_dir
LOG      := sim.log

.PHONY: sim clean

# Build, run, and pass only if the log holds the pass line
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
